// ==== design/ecc_params.svh ====
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// Data bits per word.
`define ECC_DATA_WIDTH 80

// SECDED check bits. The top one is overall parity.
`define ECC_PARITY_WIDTH 8

`define ECC_FIFO_DEPTH 8
`define ECC_COUNT_WIDTH 16

`endif

// ==== design/ecc_pkg.sv ====
`include "ecc_params.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0] data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] parity_t;
    typedef logic [`ECC_COUNT_WIDTH-1:0] count_t;

    typedef struct packed {
        data_t   data;
        parity_t parity;
    } codeword_t;

    // Column of data bit idx in the check matrix. The low bits walk the
    // Hamming positions that are not powers of two, starting at 3; the top
    // bit makes every column odd weight.
    function automatic parity_t ecc_column(input int idx);
        parity_t col;
        int      seen;
        col  = '0;
        seen = 0;
        for (int pos = 3; pos < (1 << (`ECC_PARITY_WIDTH - 1)); pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (seen == idx) begin
                    col[`ECC_PARITY_WIDTH-2:0] = pos[`ECC_PARITY_WIDTH-2:0];
                    col[`ECC_PARITY_WIDTH-1]   = ~^pos[`ECC_PARITY_WIDTH-2:0];
                end
                seen++;
            end
        end
        return col;
    endfunction

    function automatic parity_t ecc_encode(input data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                p ^= ecc_column(i); // Each check bit XORs its data bits.
            end
        end
        return p;
    endfunction

endpackage

// ==== design/ecc_word_if.sv ====
`timescale 1ns/1ps

interface ecc_word_if;
    import ecc_pkg::*;

    logic    valid;
    logic    ready;
    data_t   data;
    parity_t parity; // Check bits travel beside the data.

    modport producer (
        output valid,
        output data,
        output parity,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        input  parity,
        output ready
    );

endinterface

// ==== design/ecc_80_check.sv ====
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_80_check (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output logic             sbit_err,
    output logic             dbit_err
);
    import ecc_pkg::*;

    parity_t parity_calc;
    parity_t syndrome;
    data_t   mask;
    logic    col_hit;
    logic    chk_hit;
    logic    nonzero;

    assign parity_calc = ecc_encode(data_in);
    assign syndrome    = parity_in ^ parity_calc;
    assign nonzero     = |syndrome;

    // A check-bit error leaves a single syndrome bit set.
    assign chk_hit = $onehot(syndrome);

    // Match the syndrome against every data column.
    always_comb begin
        mask = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (syndrome == ecc_column(i)) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign col_hit = |mask;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = ~bypass & (col_hit | chk_hit);
    assign dbit_err = ~bypass & nonzero & ~col_hit & ~chk_hit; // Uncorrectable syndrome.

endmodule

// ==== design/ecc_write_encoder.sv ====
`timescale 1ns/1ps

module ecc_write_encoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  ecc_pkg::data_t       wr_data,
    input  ecc_pkg::codeword_t   wr_inject,
    ecc_word_if.producer         out
);
    import ecc_pkg::*;

    logic      run_q;
    logic      valid_q;
    logic      take;
    codeword_t cw_next;
    codeword_t cw_q;

    // Stage drains or refills in the same cycle.
    assign wr_ready = run_q & (~valid_q | out.ready);
    assign take     = wr_valid & wr_ready;

    always_comb begin
        cw_next.data   = wr_data ^ wr_inject.data;
        cw_next.parity = ecc_encode(wr_data) ^ wr_inject.parity; // Diagnostic flips.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1; // Open the port one cycle after reset.
            if (wr_ready) begin
                valid_q <= wr_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cw_q <= cw_next;
        end
    end

    assign out.valid  = valid_q;
    assign out.data   = cw_q.data;
    assign out.parity = cw_q.parity;

endmodule

// ==== design/ecc_codeword_fifo.sv ====
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_codeword_fifo (
    input logic          clk,
    input logic          reset,
    ecc_word_if.consumer in,
    ecc_word_if.producer out
);
    import ecc_pkg::*;

    localparam int PTR_W = $clog2(`ECC_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`ECC_FIFO_DEPTH + 1);

    codeword_t        mem [`ECC_FIFO_DEPTH];
    codeword_t        head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`ECC_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(`ECC_FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = in.valid & in.ready;
    assign pop   = out.valid & out.ready;

    assign in.ready  = ~full;
    assign out.valid = ~empty;

    // Head is read straight from storage.
    assign head       = mem[rd_ptr];
    assign out.data   = head.data;
    assign out.parity = head.parity;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in.data, in.parity};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

endmodule

// ==== design/ecc_read_corrector.sv ====
`timescale 1ns/1ps

module ecc_read_corrector (
    input  logic             clk,
    input  logic             reset,
    ecc_word_if.consumer     in,
    input  logic             bypass,
    output logic             rd_valid,
    input  logic             rd_ready,
    output ecc_pkg::data_t   rd_data,
    output logic             rd_sbit_err,
    output logic             rd_dbit_err,
    output ecc_pkg::count_t  sbit_count,
    output ecc_pkg::count_t  dbit_count
);
    import ecc_pkg::*;

    data_t chk_data;
    logic  chk_sbit;
    logic  chk_dbit;
    logic  take;
    logic  deliver;

    ecc_80_check u_check (
        .data_in   (in.data),
        .parity_in (in.parity),
        .bypass    (bypass),
        .data_out  (chk_data),
        .sbit_err  (chk_sbit),
        .dbit_err  (chk_dbit)
    );

    assign in.ready = ~rd_valid | rd_ready;
    assign take     = in.valid & in.ready;
    assign deliver  = rd_valid & rd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid    <= 1'b0;
            rd_sbit_err <= 1'b0;
            rd_dbit_err <= 1'b0;
        end else if (in.ready) begin
            rd_valid    <= in.valid;
            rd_sbit_err <= take & chk_sbit;
            rd_dbit_err <= take & chk_dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rd_data <= chk_data;
        end
    end

    // Count on delivery and hold at the top.
    always_ff @(posedge clk) begin
        if (reset) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else if (deliver) begin
            if (rd_sbit_err && sbit_count != '1) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (rd_dbit_err && dbit_count != '1) begin
                dbit_count <= dbit_count + 1'b1;
            end
        end
    end

endmodule

// ==== design/ecc_fifo_top.sv ====
`timescale 1ns/1ps

module ecc_fifo_top (
    input  logic               clk,
    input  logic               reset,
    // Write side.
    input  logic               wr_valid,
    output logic               wr_ready,
    input  ecc_pkg::data_t     wr_data,
    input  ecc_pkg::codeword_t wr_inject,
    input  logic               bypass,
    // Read side.
    output logic               rd_valid,
    input  logic               rd_ready,
    output ecc_pkg::data_t     rd_data,
    output logic               rd_sbit_err,
    output logic               rd_dbit_err,
    output ecc_pkg::count_t    sbit_count,
    output ecc_pkg::count_t    dbit_count
);

    ecc_word_if enc_to_fifo ();
    ecc_word_if fifo_to_corr ();

    ecc_write_encoder u_encoder (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_data   (wr_data),
        .wr_inject (wr_inject),
        .out       (enc_to_fifo.producer)
    );

    ecc_codeword_fifo u_fifo (
        .clk   (clk),
        .reset (reset),
        .in    (enc_to_fifo.consumer),
        .out   (fifo_to_corr.producer)
    );

    ecc_read_corrector u_corrector (
        .clk         (clk),
        .reset       (reset),
        .in          (fifo_to_corr.consumer),
        .bypass      (bypass),
        .rd_valid    (rd_valid),
        .rd_ready    (rd_ready),
        .rd_data     (rd_data),
        .rd_sbit_err (rd_sbit_err),
        .rd_dbit_err (rd_dbit_err),
        .sbit_count  (sbit_count),
        .dbit_count  (dbit_count)
    );

endmodule

// ==== verif/ecc_fifo_properties.sv ====
`timescale 1ns/1ps

module ecc_fifo_properties (
    input logic           clk,
    input logic           reset,
    input logic           wr_ready,
    input logic           bypass,
    input logic           rd_valid,
    input logic           rd_ready,
    input ecc_pkg::data_t rd_data,
    input logic           rd_sbit_err,
    input logic           rd_dbit_err
);

    a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rd_sbit_err && rd_dbit_err))
        else $error("rd_sbit_err and rd_dbit_err both high");

    // Output holds under back-pressure.
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
        else $error("rd_valid or rd_data changed while rd_ready low");

    a_reset_idle: assert property (@(posedge clk)
        reset |=> (!wr_ready && !rd_valid))
        else $error("wr_ready or rd_valid high during reset");

    a_bypass_quiet: assert property (@(posedge clk) disable iff (reset)
        bypass |-> !(rd_sbit_err || rd_dbit_err))
        else $error("error flag raised with bypass high");

endmodule

bind ecc_fifo_top ecc_fifo_properties u_props (
    .clk         (clk),
    .reset       (reset),
    .wr_ready    (wr_ready),
    .bypass      (bypass),
    .rd_valid    (rd_valid),
    .rd_ready    (rd_ready),
    .rd_data     (rd_data),
    .rd_sbit_err (rd_sbit_err),
    .rd_dbit_err (rd_dbit_err)
);

// ==== verif/ecc_fifo_tb.sv ====
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_fifo_tb;
    import ecc_pkg::*;

    localparam int ROWS        = 48;
    localparam int CW_W        = `ECC_DATA_WIDTH + `ECC_PARITY_WIDTH;
    localparam int LIMIT       = ROWS * 24 + 200;
    localparam int KIND_CLEAN  = 0;
    localparam int KIND_DATA   = 1;
    localparam int KIND_PARITY = 2;
    localparam int KIND_DOUBLE = 3;

    typedef struct {
        data_t data;
        logic  sbit;
        logic  dbit;
    } exp_t;

    logic      clk;
    logic      reset;
    logic      wr_valid;
    logic      wr_ready;
    data_t     wr_data;
    codeword_t wr_inject;
    logic      bypass;
    logic      rd_valid;
    logic      rd_ready;
    data_t     rd_data;
    logic      rd_sbit_err;
    logic      rd_dbit_err;
    count_t    sbit_count;
    count_t    dbit_count;

    data_t     row_data [ROWS];
    codeword_t row_inject [ROWS];
    logic      row_bypass [ROWS];
    int        row_kind [ROWS];
    exp_t      exp_q [$];
    exp_t      got_exp;
    int        seed = 32'hfa94;
    int        cycles = 0;
    int        exp_sbit_total = 0;
    int        exp_dbit_total = 0;
    int        data_errs = 0;
    int        flag_errs = 0;
    int        count_errs = 0;
    int        other_errs = 0;

    ecc_fifo_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            count_errs++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic fill_table();
        logic [95:0]     raw;
        logic [CW_W-1:0] flips;
        int              p0;
        int              p1;
        for (int i = 0; i < ROWS; i++) begin
            raw   = {$random(seed), $random(seed), $random(seed)};
            flips = '0;
            p0    = int'($unsigned($random(seed)) % CW_W);
            p1    = int'($unsigned($random(seed)) % (CW_W - 1));
            if (p1 >= p0) begin
                p1++; // Second flip always lands elsewhere.
            end
            row_kind[i]   = i % 4;
            row_bypass[i] = (i >= 16) && (i < 28);
            case (row_kind[i])
                KIND_DATA:   flips[`ECC_PARITY_WIDTH + (p0 % `ECC_DATA_WIDTH)] = 1'b1;
                KIND_PARITY: flips[p0 % `ECC_PARITY_WIDTH] = 1'b1;
                KIND_DOUBLE: begin
                    flips[p0] = 1'b1;
                    flips[p1] = 1'b1;
                end
                default: flips = '0;
            endcase
            row_data[i]   = raw[`ECC_DATA_WIDTH-1:0];
            row_inject[i] = flips;
        end
    endtask

    function automatic exp_t expect_row(input int i);
        exp_t e;
        e.data = row_data[i];
        e.sbit = 1'b0;
        e.dbit = 1'b0;
        if (row_bypass[i] || row_kind[i] == KIND_DOUBLE) begin
            e.data = row_data[i] ^ row_inject[i].data; // Raw flipped data.
        end
        if (!row_bypass[i]) begin
            e.sbit = (row_kind[i] == KIND_DATA) || (row_kind[i] == KIND_PARITY);
            e.dbit = (row_kind[i] == KIND_DOUBLE);
        end
        return e;
    endfunction

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Random read stalls on about one cycle in four.
    always @(posedge clk) begin
        rd_ready <= reset ? 1'b0 : (($random(seed) & 3) != 0);
    end

    always @(negedge clk) begin
        if (!reset && rd_valid && rd_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Output word delivered while no word was pending");
            end else begin
                got_exp = exp_q.pop_front();
                check_data("rd_data", rd_data, got_exp.data);
                check_flag("rd_sbit_err", rd_sbit_err, got_exp.sbit);
                check_flag("rd_dbit_err", rd_dbit_err, got_exp.dbit);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run stopped after %0d cycles, output words still pending", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        wr_valid  = 1'b0;
        wr_data   = '0;
        wr_inject = '0;
        bypass    = 1'b0;
        rd_ready  = 1'b0;
        fill_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("wr_ready", wr_ready, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        check_flag("rd_sbit_err", rd_sbit_err, 1'b0);
        check_flag("rd_dbit_err", rd_dbit_err, 1'b0);
        check_count("sbit_count", sbit_count, '0);
        check_count("dbit_count", dbit_count, '0);
        @(posedge clk);
        for (int i = 0; i < ROWS; i++) begin
            if (row_bypass[i] != bypass) begin
                wr_valid <= 1'b0;
                wait_drain(); // Bypass moves only on an empty path.
                bypass <= row_bypass[i];
                @(posedge clk);
            end
            wr_valid  <= 1'b1;
            wr_data   <= row_data[i];
            wr_inject <= row_inject[i];
            @(negedge clk);
            while (!wr_ready) begin
                @(negedge clk);
            end
            exp_q.push_back(expect_row(i));
            if (!row_bypass[i] && row_kind[i] == KIND_DOUBLE) begin
                exp_dbit_total++;
            end else if (!row_bypass[i] && row_kind[i] != KIND_CLEAN) begin
                exp_sbit_total++;
            end
            @(posedge clk);
        end
        wr_valid <= 1'b0;
        wait_drain();
        repeat (2) @(negedge clk);
        check_count("sbit_count", sbit_count, count_t'(exp_sbit_total));
        check_count("dbit_count", dbit_count, count_t'(exp_dbit_total));
        $display("Errors: data %0d, flag %0d, count %0d, other %0d",
                 data_errs, flag_errs, count_errs, other_errs);
        if (data_errs + flag_errs + count_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/ecc_pkg.sv
design/ecc_word_if.sv
design/ecc_80_check.sv
design/ecc_write_encoder.sv
design/ecc_codeword_fifo.sv
design/ecc_read_corrector.sv
design/ecc_fifo_top.sv
verif/ecc_fifo_properties.sv
verif/ecc_fifo_tb.sv

// ==== Makefile ====
# Verilator build and run of the ECC FIFO testbench.

TOP      ?= ecc_fifo_tb
LOG      ?= sim.log
BUILD    ?= obj_dir
FILELIST ?= tb.f
VFLAGS   ?= --binary --timing --assert -j 0
PASS_MSG := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the result"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP LOG BUILD FILELIST VFLAGS"

test:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
